// ==== Bender.yml ====
package:
  name: map_186

sources:
  - files:
      - design/map_186_pkg.sv
      - design/map_186_regs.sv
      - design/map_186_prg_map.sv
      - design/map_186_chr_map.sv
      - design/map_186_readback.sv
      - design/map_186_top.sv
  - target: test
    files:
      - verif/tb_clk_gen.sv
      - verif/tb_map_186.sv

// ==== design/map_186_chr_map.sv ====
`timescale 1ns/1ps

module map_186_chr_map (
	input  logic [13:0] ppu_addr,
	input  logic        ppu_oe,
	input  logic        ppu_we,
	input  logic        cfg_mir_v,
	input  logic        cfg_chr_ram,
	output logic [12:0] chr_addr,
	output logic        chr_oe,
	output logic        chr_ce,
	output logic        chr_we,
	output logic        ciram_a10,
	output logic        ciram_ce
);

	// pattern tables sit below 0x2000, the chr chip is addressed directly
	assign chr_addr = ppu_addr[12:0];
	assign chr_oe   = !ppu_oe;

	// ciram_ce is active low, so inverting a13 enables the console nametable
	// ram above 0x2000 while chr_ce selects the pattern tables below it
	assign ciram_ce = !ppu_addr[13];
	assign chr_ce   = ciram_ce;

	// vertical mirroring splits on a10, horizontal on a11
	assign ciram_a10 = cfg_mir_v ? ppu_addr[10] : ppu_addr[11];

	// chr writes only make sense when the board carries chr ram
	assign chr_we = cfg_chr_ram ? (!ppu_we && ciram_ce) : 1'b0;

endmodule

// ==== design/map_186_pkg.sv ====
package map_186_pkg;

	// map number reported to the save-state host at slot 127
	localparam logic [7:0] map_num = 8'd27;

	// cpu_addr[14:4] of the 0x4200-0x420F register window
	localparam logic [10:0] reg_base_hi = 11'h420;

	// countdown width for the tape ready timer
	localparam int tape_delay_w = 7;

	// bank register widths
	localparam int prg_bank_w = 8;
	localparam int ram_bank_w = 2;

	// register offsets decoded from cpu_addr[1:0]
	typedef enum logic [1:0] {
		reg_ram_bank = 2'd0,
		reg_prg_bank = 2'd1,
		reg_tape_cmd = 2'd2,
		reg_unused   = 2'd3
	} reg_off_e;

	// save-state slots on ss_addr
	// slot 2 packs {tape_ready, read_reg, ram_bank} into the low bits
	typedef enum logic [7:0] {
		ss_prg_bank   = 8'd0,
		ss_tape_delay = 8'd1,
		ss_flags      = 8'd2,
		ss_map_num    = 8'd127
	} ss_slot_e;

endpackage

// ==== design/map_186_prg_map.sv ====
`timescale 1ns/1ps

module map_186_prg_map import map_186_pkg::*; (
	input  logic [15:0]           cpu_addr,
	input  logic                  cpu_rw,
	input  logic                  cpu_ce,
	input  logic                  m2,
	input  logic [prg_bank_w-1:0] prg_bank,
	input  logic [ram_bank_w-1:0] ram_bank,
	output logic [18:0]           prg_addr,
	output logic [12:0]           srm_addr,
	output logic                  prg_oe,
	output logic                  ram_ce,
	output logic                  ram_we,
	output logic                  rom_ce
);

	logic        ram_area;
	logic        save_area;
	logic [11:0] save_off;
	logic [5:0]  prg_hi;

	// 0x6000-0x7FFF work ram, cpu_ce already limits this to the lower half
	assign ram_area  = (cpu_addr[14:13] == 2'b11) && cpu_ce;
	// 0x4400-0x4FFF is a second view into the first ram bank
	assign save_area = (cpu_addr[15:12] == 4'h4) && (cpu_addr[11:0] >= 12'h400);
	assign save_off  = cpu_addr[11:0] - 12'h400;

	always_comb begin
		if (cpu_ce) begin
			if (save_area) begin
				prg_hi = 6'd0;
			end else begin
				prg_hi = {{(6 - ram_bank_w){1'b0}}, ram_bank};
			end
		end else if (!cpu_addr[14]) begin
			// 0x8000-0xBFFF is the switchable 16 KB page
			prg_hi = {prg_bank[4:0], cpu_addr[13]};
		end else begin
			// 0xC000-0xFFFF stays on the first 16 KB of rom
			prg_hi = {5'd0, cpu_addr[13]};
		end
	end

	assign prg_addr[12:0]  = save_area ? {1'b0, save_off} : cpu_addr[12:0];
	assign prg_addr[18:13] = prg_hi;

	assign srm_addr = cpu_addr[12:0];
	assign prg_oe   = cpu_rw;
	assign ram_we   = !cpu_rw;
	// ram strobe only during the valid half of the cpu cycle
	assign ram_ce   = (ram_area || save_area) && m2;
	assign rom_ce   = !cpu_ce;

endmodule

// ==== design/map_186_readback.sv ====
`timescale 1ns/1ps

module map_186_readback import map_186_pkg::*; (
	input  logic                    m2,
	input  logic [15:0]             cpu_addr,
	input  logic                    cpu_rw,
	input  logic                    cpu_ce,
	input  logic [7:0]              ss_addr,
	input  logic [prg_bank_w-1:0]   prg_bank,
	input  logic [ram_bank_w-1:0]   ram_bank,
	input  logic                    tape_ready,
	input  logic                    read_reg,
	input  logic [tape_delay_w-1:0] tape_delay_cnt,
	output logic                    map_cpu_oe,
	output logic [7:0]              map_cpu_dout,
	output logic [7:0]              ss_rdat
);

	logic reg_hit;

	assign reg_hit = cpu_ce && (cpu_addr[14:4] == reg_base_hi) && (cpu_addr[3:2] == 2'b00);

	// the mapper drives the data bus only in the high phase of m2
	assign map_cpu_oe = reg_hit && cpu_rw && m2;

	always_comb begin
		case (reg_off_e'(cpu_addr[1:0]))
			reg_prg_bank: map_cpu_dout = 8'h10;
			reg_tape_cmd: map_cpu_dout = tape_ready ? 8'h40 : 8'h00;
			reg_ram_bank: map_cpu_dout = 8'h00;
			reg_unused:   map_cpu_dout = 8'h00;
			default:      map_cpu_dout = 8'h00;
		endcase
	end

	// layout must mirror the restore path in the register block
	always_comb begin
		case (ss_slot_e'(ss_addr))
			ss_prg_bank:   ss_rdat = prg_bank;
			ss_tape_delay: ss_rdat = {{(8 - tape_delay_w){1'b0}}, tape_delay_cnt};
			ss_flags:      ss_rdat = {{(6 - ram_bank_w){1'b0}}, tape_ready, read_reg, ram_bank};
			ss_map_num:    ss_rdat = map_num;
			default:       ss_rdat = 8'hff;
		endcase
	end

endmodule

// ==== design/map_186_regs.sv ====
`timescale 1ns/1ps

module map_186_regs import map_186_pkg::*; #(
	parameter int unsigned tape_delay = 100
) (
	input  logic                    m2,
	input  logic                    arst_n,
	input  logic [15:0]             cpu_addr,
	input  logic [7:0]              cpu_dat,
	input  logic                    cpu_rw,
	input  logic                    cpu_ce,
	input  logic                    ss_act,
	input  logic                    ss_we,
	input  logic [7:0]              ss_addr,
	output logic [prg_bank_w-1:0]   prg_bank,
	output logic [ram_bank_w-1:0]   ram_bank,
	output logic                    tape_ready,
	output logic                    read_reg,
	output logic [tape_delay_w-1:0] tape_delay_cnt
);

	logic     reg_wr;
	logic     tape_load;
	reg_off_e reg_sel;
	ss_slot_e ss_sel;

	// a cpu write lands in the register block only inside 0x4200-0x4203
	assign reg_wr    = !cpu_rw && cpu_ce && (cpu_addr[14:4] == reg_base_hi) &&
	                   (cpu_addr[3:2] == 2'b00);
	assign reg_sel   = reg_off_e'(cpu_addr[1:0]);
	assign tape_load = reg_wr && (reg_sel == reg_tape_cmd);
	assign ss_sel    = ss_slot_e'(ss_addr);

	always_ff @(posedge m2 or negedge arst_n) begin
		if (!arst_n) begin
			prg_bank       <= '0;
			ram_bank       <= '0;
			tape_ready     <= 1'b0;
			read_reg       <= 1'b0;
			tape_delay_cnt <= '0;
		end else if (ss_act) begin
			// the host owns the registers during a save-state transfer,
			// restore data arrives on cpu_dat
			if (ss_we) begin
				case (ss_sel)
					ss_prg_bank: begin
						prg_bank <= cpu_dat[prg_bank_w-1:0];
					end
					ss_tape_delay: begin
						tape_delay_cnt <= cpu_dat[tape_delay_w-1:0];
					end
					ss_flags: begin
						{tape_ready, read_reg, ram_bank} <= cpu_dat[ram_bank_w+1:0];
					end
					default: begin
					end
				endcase
			end
		end else begin
			if (reg_wr) begin
				case (reg_sel)
					reg_ram_bank: begin
						ram_bank <= cpu_dat[7 -: ram_bank_w];
					end
					reg_prg_bank: begin
						prg_bank <= cpu_dat[prg_bank_w-1:0];
					end
					reg_tape_cmd: begin
						read_reg <= cpu_dat[4];
					end
					default: begin
					end
				endcase
			end

			// a new tape command restarts the countdown even if one is running
			if (tape_load) begin
				tape_delay_cnt <= tape_delay_w'(tape_delay);
			end else if (tape_delay_cnt != '0) begin
				tape_delay_cnt <= tape_delay_cnt - 1'b1;
				// the flag is published on the edge where the count reaches zero
				if (tape_delay_cnt == tape_delay_w'(1)) begin
					tape_ready <= read_reg;
				end
			end
		end
	end

endmodule

// ==== design/map_186_top.sv ====
`timescale 1ns/1ps

module map_186_top import map_186_pkg::*; #(
	parameter int unsigned tape_delay = 100
) (
	input  logic        m2,
	input  logic        arst_n,
	// cpu bus
	input  logic [15:0] cpu_addr,
	input  logic [7:0]  cpu_dat,
	input  logic        cpu_rw,
	input  logic        cpu_ce,
	// save-state port
	input  logic        ss_act,
	input  logic        ss_we,
	input  logic [7:0]  ss_addr,
	output logic [7:0]  ss_rdat,
	// ppu bus
	input  logic [13:0] ppu_addr,
	input  logic        ppu_oe,
	input  logic        ppu_we,
	// board configuration
	input  logic        cfg_mir_v,
	input  logic        cfg_chr_ram,
	// cpu side memory map
	output logic [18:0] prg_addr,
	output logic [12:0] srm_addr,
	output logic        prg_oe,
	output logic        ram_ce,
	output logic        ram_we,
	output logic        rom_ce,
	output logic        map_cpu_oe,
	output logic [7:0]  map_cpu_dout,
	// ppu side memory map
	output logic [12:0] chr_addr,
	output logic        chr_oe,
	output logic        chr_ce,
	output logic        chr_we,
	output logic        ciram_a10,
	output logic        ciram_ce
);

	logic [prg_bank_w-1:0]   prg_bank;
	logic [ram_bank_w-1:0]   ram_bank;
	logic                    tape_ready;
	logic                    read_reg;
	logic [tape_delay_w-1:0] tape_delay_cnt;

	map_186_regs #(
		.tape_delay(tape_delay)
	) u_regs (
		.m2            (m2),
		.arst_n        (arst_n),
		.cpu_addr      (cpu_addr),
		.cpu_dat       (cpu_dat),
		.cpu_rw        (cpu_rw),
		.cpu_ce        (cpu_ce),
		.ss_act        (ss_act),
		.ss_we         (ss_we),
		.ss_addr       (ss_addr),
		.prg_bank      (prg_bank),
		.ram_bank      (ram_bank),
		.tape_ready    (tape_ready),
		.read_reg      (read_reg),
		.tape_delay_cnt(tape_delay_cnt)
	);

	map_186_prg_map u_prg_map (
		.cpu_addr(cpu_addr),
		.cpu_rw  (cpu_rw),
		.cpu_ce  (cpu_ce),
		.m2      (m2),
		.prg_bank(prg_bank),
		.ram_bank(ram_bank),
		.prg_addr(prg_addr),
		.srm_addr(srm_addr),
		.prg_oe  (prg_oe),
		.ram_ce  (ram_ce),
		.ram_we  (ram_we),
		.rom_ce  (rom_ce)
	);

	map_186_chr_map u_chr_map (
		.ppu_addr   (ppu_addr),
		.ppu_oe     (ppu_oe),
		.ppu_we     (ppu_we),
		.cfg_mir_v  (cfg_mir_v),
		.cfg_chr_ram(cfg_chr_ram),
		.chr_addr   (chr_addr),
		.chr_oe     (chr_oe),
		.chr_ce     (chr_ce),
		.chr_we     (chr_we),
		.ciram_a10  (ciram_a10),
		.ciram_ce   (ciram_ce)
	);

	map_186_readback u_readback (
		.m2            (m2),
		.cpu_addr      (cpu_addr),
		.cpu_rw        (cpu_rw),
		.cpu_ce        (cpu_ce),
		.ss_addr       (ss_addr),
		.prg_bank      (prg_bank),
		.ram_bank      (ram_bank),
		.tape_ready    (tape_ready),
		.read_reg      (read_reg),
		.tape_delay_cnt(tape_delay_cnt),
		.map_cpu_oe    (map_cpu_oe),
		.map_cpu_dout  (map_cpu_dout),
		.ss_rdat       (ss_rdat)
	);

endmodule

// ==== src.f ====
design/map_186_pkg.sv
design/map_186_regs.sv
design/map_186_prg_map.sv
design/map_186_chr_map.sv
design/map_186_readback.sv
design/map_186_top.sv
verif/tb_clk_gen.sv
verif/tb_map_186.sv

// ==== verif/map_186_patterns.txt ====
# op addr data cfg exp_addr exp_flags exp_data, all hex
# R flags {ram_ce,rom_ce,map_cpu_oe}, T waits data edges after the last W, P data {ppu_oe,ppu_we}
# P cfg {cfg_chr_ram,cfg_mir_v}, P flags {chr_we,chr_ce,ciram_ce,ciram_a10}, S exp_data ss_rdat
# state after reset
R 4202 00 0 00202 1 00
R 8000 00 0 00000 2 00
R 9abc 00 0 01abc 2 00
R 4201 00 0 00201 1 10
# prg bank 0x15, ram bank 2
W 4201 15 0 00000 0 00
W 4200 80 0 00000 0 00
R 8000 00 0 54000 2 00
R a123 00 0 56123 2 00
R c000 00 0 00000 2 00
R fffe 00 0 03ffe 2 00
R 6000 00 0 04000 4 00
R 7fff 00 0 05fff 4 00
R 4400 00 0 00000 4 00
R 4abc 00 0 006bc 4 00
R 4fff 00 0 00bff 4 00
R 43ff 00 0 043ff 0 00
R 4201 00 0 04201 1 10
# outside 0x4200-0x4203, no effect
W 4205 03 0 00000 0 00
R 8000 00 0 54000 2 00
# tape command with bit 4 set
W 4202 10 0 00000 0 00
T 4202 63 0 00000 0 00
T 4202 64 0 00000 0 40
T 4202 70 0 00000 0 40
R 4201 00 0 04201 1 10
R 4202 00 0 04202 1 40
# ppu side
P 0123 03 0 00123 6 00
P 2400 03 0 00400 0 00
P 2400 03 1 00400 1 00
P 2800 03 0 00800 1 00
P 2800 03 1 00800 0 00
P 2c00 01 1 00c00 1 01
P 1fff 02 0 01fff 7 00
P 1fff 02 2 01fff f 00
P 1400 02 3 01400 f 00
P 2000 02 2 00000 0 00
P 0800 03 2 00800 7 00
# save state, the timer holds while ss_act is high
W 4202 10 0 00000 0 00
S 0001 00 0 00000 0 64
S 0000 00 0 00000 0 15
S 0002 00 0 00000 0 0e
S 007f 00 0 00000 0 1b
S 0003 00 0 00000 0 ff
S 0080 00 0 00000 0 ff
S 0001 00 0 00000 0 64
L 0000 07 0 00000 0 00
L 0002 01 0 00000 0 00
L 0001 05 0 00000 0 00
X 4201 3f 0 00000 0 00
X 4200 c0 0 00000 0 00
S 0000 00 0 00000 0 07
S 0002 00 0 00000 0 01
S 0001 00 0 00000 0 05
# restored banks, prg 7 and ram 1
R 8000 00 0 1c000 2 00
R bfff 00 0 1ffff 2 00
R 6abc 00 0 02abc 4 00
R 4800 00 0 00400 4 00
R 4202 00 0 02202 1 00
S 0001 00 0 00000 0 00
W 4201 02 0 00000 0 00
R 8000 00 0 08000 2 00

// ==== verif/tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen #(
	parameter int half_period  = 2,
	parameter int reset_cycles = 8
) (
	output logic m2,
	output logic arst_n
);

	initial begin
		m2 = 1'b0;
		forever begin
			#(half_period) m2 = ~m2;
		end
	end

	// release reset on a falling edge so it never lands on a sampling edge
	initial begin
		arst_n = 1'b0;
		repeat (reset_cycles) @(posedge m2);
		@(negedge m2);
		arst_n = 1'b1;
	end

endmodule

// ==== verif/tb_map_186.sv ====
`timescale 1ns/1ps

module tb_map_186;

	localparam int unsigned tape_delay   = 100;
	localparam int          reset_cycles = 8;
	localparam int          max_patterns = 128;

	logic        m2;
	logic        arst_n;
	logic [15:0] cpu_addr;
	logic [7:0]  cpu_dat;
	logic        cpu_rw;
	logic        cpu_ce;
	logic        ss_act;
	logic        ss_we;
	logic [7:0]  ss_addr;
	logic [7:0]  ss_rdat;
	logic [13:0] ppu_addr;
	logic        ppu_oe;
	logic        ppu_we;
	logic        cfg_mir_v;
	logic        cfg_chr_ram;
	logic [18:0] prg_addr;
	logic [12:0] srm_addr;
	logic        prg_oe;
	logic        ram_ce;
	logic        ram_we;
	logic        rom_ce;
	logic        map_cpu_oe;
	logic [7:0]  map_cpu_dout;
	logic [12:0] chr_addr;
	logic        chr_oe;
	logic        chr_ce;
	logic        chr_we;
	logic        ciram_a10;
	logic        ciram_ce;

	// one entry per bus operation from the pattern file
	logic [7:0]  pat_op        [max_patterns];
	logic [15:0] pat_addr      [max_patterns];
	logic [7:0]  pat_data      [max_patterns];
	logic [3:0]  pat_cfg       [max_patterns];
	logic [18:0] pat_exp_addr  [max_patterns];
	logic [3:0]  pat_exp_flags [max_patterns];
	logic [7:0]  pat_exp_data  [max_patterns];

	int pat_count;
	int error_count;
	int check_count;
	int edge_cnt;
	int wr_edge;
	int cycle_limit;

	tb_clk_gen #(
		.half_period (2),
		.reset_cycles(reset_cycles)
	) u_clk_gen (
		.m2    (m2),
		.arst_n(arst_n)
	);

	map_186_top #(
		.tape_delay(tape_delay)
	) uut (
		.m2          (m2),
		.arst_n      (arst_n),
		.cpu_addr    (cpu_addr),
		.cpu_dat     (cpu_dat),
		.cpu_rw      (cpu_rw),
		.cpu_ce      (cpu_ce),
		.ss_act      (ss_act),
		.ss_we       (ss_we),
		.ss_addr     (ss_addr),
		.ss_rdat     (ss_rdat),
		.ppu_addr    (ppu_addr),
		.ppu_oe      (ppu_oe),
		.ppu_we      (ppu_we),
		.cfg_mir_v   (cfg_mir_v),
		.cfg_chr_ram (cfg_chr_ram),
		.prg_addr    (prg_addr),
		.srm_addr    (srm_addr),
		.prg_oe      (prg_oe),
		.ram_ce      (ram_ce),
		.ram_we      (ram_we),
		.rom_ce      (rom_ce),
		.map_cpu_oe  (map_cpu_oe),
		.map_cpu_dout(map_cpu_dout),
		.chr_addr    (chr_addr),
		.chr_oe      (chr_oe),
		.chr_ce      (chr_ce),
		.chr_we      (chr_we),
		.ciram_a10   (ciram_a10),
		.ciram_ce    (ciram_ce)
	);

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] expected);
		check_count = check_count + 1;
		if (got !== expected) begin
			error_count = error_count + 1;
			$display("Fail %s: got 0x%0h, expected 0x%0h at %0t ns", name, got, expected, $time);
		end
	endtask

	task automatic drive_idle();
		cpu_addr = 16'hffff;
		cpu_dat  = 8'h00;
		cpu_rw   = 1'b1;
		cpu_ce   = 1'b0;
		ss_act   = 1'b0;
		ss_we    = 1'b0;
		ss_addr  = 8'h00;
		ppu_addr = 14'h3fff;
		ppu_oe   = 1'b1;
		ppu_we   = 1'b1;
	endtask

	task automatic load_patterns();
		int          fd;
		int          ch;
		int          n;
		logic [31:0] f_addr;
		logic [31:0] f_data;
		logic [31:0] f_cfg;
		logic [31:0] f_ea;
		logic [31:0] f_ef;
		logic [31:0] f_ed;
		fd = $fopen("verif/map_186_patterns.txt", "r");
		if (fd == 0) begin
			$display("Error: the pattern file verif/map_186_patterns.txt could not be opened");
			error_count = error_count + 1;
		end else begin
			ch = $fgetc(fd);
			while (ch != -1) begin
				if (ch == "#") begin
					while (ch != -1 && ch != 8'h0a) begin
						ch = $fgetc(fd);
					end
				end else if (ch == " " || ch == 8'h0a || ch == 8'h0d || ch == 8'h09) begin
					ch = $fgetc(fd);
				end else if (pat_count >= max_patterns) begin
					$display("Error: the pattern file holds more operations than the testbench stores");
					error_count = error_count + 1;
					ch = -1;
				end else begin
					n = $fscanf(fd, "%h %h %h %h %h %h", f_addr, f_data, f_cfg, f_ea, f_ef, f_ed);
					if (n != 6) begin
						$display("Error: pattern line %0d is incomplete", pat_count + 1);
						error_count = error_count + 1;
						ch = -1;
					end else begin
						pat_op[pat_count]        = ch[7:0];
						pat_addr[pat_count]      = f_addr[15:0];
						pat_data[pat_count]      = f_data[7:0];
						pat_cfg[pat_count]       = f_cfg[3:0];
						pat_exp_addr[pat_count]  = f_ea[18:0];
						pat_exp_flags[pat_count] = f_ef[3:0];
						pat_exp_data[pat_count]  = f_ed[7:0];
						pat_count = pat_count + 1;
						ch = $fgetc(fd);
					end
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic run_pattern(input int i);
		logic [7:0] op;
		op = pat_op[i];
		@(negedge m2);
		drive_idle();
		cfg_mir_v   = pat_cfg[i][0];
		cfg_chr_ram = pat_cfg[i][1];
		case (op)
			"W", "X": begin
				cpu_addr = pat_addr[i];
				cpu_dat  = pat_data[i];
				cpu_rw   = 1'b0;
				cpu_ce   = ~pat_addr[i][15];
				ss_act   = (op == "X");
				ss_addr  = 8'h10;
				@(posedge m2);
				#1;
				check_value("prg_oe", prg_oe, 1'b0);
				check_value("ram_we", ram_we, 1'b1);
				if (op == "W") begin
					wr_edge = edge_cnt;
				end
			end
			"R": begin
				cpu_addr = pat_addr[i];
				cpu_ce   = ~pat_addr[i][15];
				// the mapper keeps off the data bus and the ram while m2 is low
				#1;
				check_value("map_cpu_oe (m2 low)", map_cpu_oe, 1'b0);
				check_value("ram_ce (m2 low)", ram_ce, 1'b0);
				@(posedge m2);
				#1;
				check_value("prg_addr", prg_addr, pat_exp_addr[i]);
				check_value("srm_addr", srm_addr, pat_addr[i][12:0]);
				check_value("prg_oe", prg_oe, 1'b1);
				check_value("ram_we", ram_we, 1'b0);
				check_value("ram_ce", ram_ce, pat_exp_flags[i][2]);
				check_value("rom_ce", rom_ce, pat_exp_flags[i][1]);
				check_value("map_cpu_oe", map_cpu_oe, pat_exp_flags[i][0]);
				check_value("map_cpu_dout", map_cpu_dout, pat_exp_data[i]);
			end
			"T": begin
				// hold the read until the given number of edges follow the last write
				cpu_addr = pat_addr[i];
				cpu_ce   = ~pat_addr[i][15];
				@(posedge m2);
				#1;
				while (edge_cnt < wr_edge + int'(pat_data[i])) begin
					@(posedge m2);
					#1;
				end
				check_value("map_cpu_dout", map_cpu_dout, pat_exp_data[i]);
			end
			"P": begin
				ppu_addr = pat_addr[i][13:0];
				ppu_oe   = pat_data[i][1];
				ppu_we   = pat_data[i][0];
				@(posedge m2);
				#1;
				check_value("chr_addr", chr_addr, pat_exp_addr[i]);
				check_value("chr_we", chr_we, pat_exp_flags[i][3]);
				check_value("chr_ce", chr_ce, pat_exp_flags[i][2]);
				check_value("ciram_ce", ciram_ce, pat_exp_flags[i][1]);
				check_value("ciram_a10", ciram_a10, pat_exp_flags[i][0]);
				check_value("chr_oe", chr_oe, pat_exp_data[i]);
			end
			"L", "S": begin
				ss_act  = 1'b1;
				ss_we   = (op == "L");
				ss_addr = pat_addr[i][7:0];
				cpu_dat = pat_data[i];
				@(posedge m2);
				#1;
				if (op == "S") begin
					check_value("ss_rdat", ss_rdat, pat_exp_data[i]);
				end
			end
			default: begin
				$display("Error: pattern %0d has an unknown operation kind", i + 1);
				error_count = error_count + 1;
			end
		endcase
	endtask

	// cycle counter, also bounds the run
	always @(posedge m2) begin
		edge_cnt = edge_cnt + 1;
		if (cycle_limit > 0 && edge_cnt > cycle_limit) begin
			$display("Timeout: the run went past %0d cycles without finishing", cycle_limit);
			error_count = error_count + 1;
			$display("checks: %0d  errors: %0d", check_count, error_count);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	initial begin
		error_count = 0;
		check_count = 0;
		edge_cnt    = 0;
		wr_edge     = 0;
		cycle_limit = 0;
		pat_count   = 0;
		drive_idle();
		cfg_mir_v   = 1'b0;
		cfg_chr_ram = 1'b0;
		load_patterns();
		// longest operation is a tape wait of tape_delay cycles plus a few edges
		cycle_limit = pat_count * (int'(tape_delay) + 4) + reset_cycles;
		@(posedge arst_n);
		if (pat_count == 0) begin
			$display("Error: no bus operations were loaded");
			error_count = error_count + 1;
		end
		for (int i = 0; i < pat_count; i++) begin
			run_pattern(i);
		end
		@(negedge m2);
		drive_idle();
		$display("checks: %0d  errors: %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule
